/* Makefile */
# Verilator flow for the Ethernet receive switch

VERILATOR ?= verilator
FILELIST  ?= filelist.f
TB_TOP    ?= ethRxSwitchTb
RTL_TOP   ?= ethRxSwitch
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@if ! grep -q "sim passed" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* filelist.f */
+incdir+rtl
rtl/ethSwitchPkg.sv
rtl/rxFrameParser.sv
rtl/rxFrameCheck.sv
rtl/fpgaForwardDb.sv
rtl/fwdDecision.sv
rtl/ethRxSwitch.sv
test/tbClkGen.sv
test/ethRxSwitchTb.sv

/* rtl/ethRxSwitch.sv */
// ######################################################################
// Top level of the receive switch, both Ethernet receive paths
// around one shared forwarding database
// ######################################################################
`include "ethSwitch_settings.svh"
`default_nettype none

module ethRxSwitch (
  input  wire                              RxClk,
  input  wire                              arstN,
  input  wire ethSwitchPkg::rxBeat_t [1:0] rxIn,        // Index 0 is Eth1
  input  wire ethSwitchPkg::portMask_t     portActive,
  input  wire ethSwitchPkg::boardId_t      boardId,
  input  wire                              clearErrors,
  output wire ethSwitchPkg::rxResult_t [1:0] rxResult,
  output wire ethSwitchPkg::rxStats_t [1:0]  rxStats
);

  wire ethSwitchPkg::ethHeader_t [1:0] header;
  wire [1:0]                           hdrDone;
  wire ethSwitchPkg::mac_t [1:0]       srcMac;
  wire ethSwitchPkg::mac_t [1:0]       hostMac;
  wire ethSwitchPkg::boardMap_t [1:0]  boardMap;

  for (genvar i = `ETH_IDX_ETH1; i <= `ETH_IDX_ETH2; i++) begin : gEthPort
    wire                      dataStrobe;
    wire                      frameEnd;
    wire ethSwitchPkg::byte_t dataByte;

    rxFrameParser rxParser_i (
      .RxClk      (RxClk),
      .arstN      (arstN),
      .rxBeat     (rxIn[i]),
      .header     (header[i]),
      .hdrDone    (hdrDone[i]),
      .dataStrobe (dataStrobe),
      .dataByte   (dataByte),
      .frameEnd   (frameEnd)
    );

    assign srcMac[i] = header[i].srcMac;  // Learning input of the database

    rxFrameCheck rxCheck_i (
      .RxClk       (RxClk),
      .arstN       (arstN),
      .clearErrors (clearErrors),
      .etherType   (header[i].etherType),
      .hdrDone     (hdrDone[i]),
      .dataStrobe  (dataStrobe),
      .dataByte    (dataByte),
      .frameEnd    (frameEnd),
      .frameDone   (rxResult[i].frameDone),
      .ipv4Err     (rxResult[i].ipv4Err),
      .stats       (rxStats[i])
    );

    fwdDecision #(.inPort(i)) fwdDecision_i (
      .RxClk      (RxClk),
      .arstN      (arstN),
      .header     (header[i]),
      .hdrDone    (hdrDone[i]),
      .portActive (portActive),
      .boardId    (boardId),
      .hostMac    (hostMac),
      .boardMap   (boardMap),
      .fwdValid   (rxResult[i].fwdValid),
      .fwdMask    (rxResult[i].fwdMask)
    );
  end

  fpgaForwardDb fwdDb_i (
    .RxClk      (RxClk),
    .arstN      (arstN),
    .portActive (portActive),
    .hdrDone    (hdrDone),
    .srcMac     (srcMac),
    .hostMac    (hostMac),
    .boardMap   (boardMap)
  );

endmodule

`default_nettype wire

/* rtl/ethSwitchPkg.sv */
// ######################################################################
// Types shared by the receive switch RTL and its testbench
// ######################################################################
`default_nettype none

package ethSwitchPkg;

  typedef logic [7:0]  byte_t;      // One data byte
  typedef logic [47:0] mac_t;
  typedef logic [3:0]  boardId_t;   // FPGA board id, low nibble of an FPGA MAC
  typedef logic [3:0]  portMask_t;  // One bit per out-port
  typedef logic [15:0] boardMap_t;  // One bit per board id
  typedef logic [15:0] count16_t;
  typedef logic [7:0]  count8_t;

  // Receive FSM
  typedef enum logic [1:0] {
    rxIdle   = 2'd0,  // Preamble, waiting for SFD
    rxHeader = 2'd1,  // Capturing the 14 header bytes
    rxData   = 2'd2   // Payload up to end of valid
  } rxState_e;

  // Byte as it arrives from the PHY side
  typedef struct packed {
    logic  valid;
    byte_t data;
  } rxBeat_t;

  typedef struct packed {
    mac_t        destMac;
    mac_t        srcMac;
    logic [15:0] etherType;
  } ethHeader_t;

  // Per in-port results, all one-cycle pulses
  typedef struct packed {
    logic      fwdValid;
    portMask_t fwdMask;
    logic      frameDone;
    logic      ipv4Err;    // Valid with frameDone
  } rxResult_t;

  typedef struct packed {
    count16_t numPacketRecv;
    count8_t  numIpv4Err;
  } rxStats_t;

endpackage

`default_nettype wire

/* rtl/ethSwitch_settings.svh */
// ######################################################################
// Constants for the Ethernet receive and forwarding logic
// Included by every RTL file that needs port indices or frame fields
// ######################################################################
`ifndef ETH_SWITCH_SETTINGS_SVH
`define ETH_SWITCH_SETTINGS_SVH

// Out-ports of the switch
`define ETH_NUM_PORTS      4
`define ETH_IDX_ETH1       0
`define ETH_IDX_ETH2       1
`define ETH_IDX_PS         2
`define ETH_IDX_RT         3

// FPGA MAC layout is company id, 16-bit interface field, 8-bit board id
`define ETH_LCSR_CID       24'hFA610E
`define ETH_LCSR_CID_MCAST (`ETH_LCSR_CID | 24'h010000)  // Group bit set
`define ETH_FPGA_PS_MAC    16'h0300
`define ETH_FPGA_RT_MAC    16'h1394
`define ETH_BROADCAST_MAC  48'hFFFF_FFFF_FFFF
`define ETH_MAC_BYTES      6

// Frame layout
`define ETH_SFD            8'hD5
`define ETH_HDR_BYTES      14
`define ETH_DEST_MAC_OFS   0   // Byte offsets within the header
`define ETH_SRC_MAC_OFS    6
`define ETH_TYPE_OFS       12
`define ETH_TYPE_IPV4      16'h0800
`define ETH_IPV4_HDR_BYTES 20

`endif

/* rtl/fpgaForwardDb.sv */
// ######################################################################
// Forwarding database of Eth1 and Eth2, learns host MACs and FPGA boards
// Updated on each header's hdrDone edge, cleared while the port is down
// ######################################################################
`include "ethSwitch_settings.svh"
`default_nettype none

module fpgaForwardDb (
  input  wire                            RxClk,
  input  wire                            arstN,
  input  wire ethSwitchPkg::portMask_t   portActive,
  input  wire [1:0]                      hdrDone,   // One per Ethernet in-port
  input  wire ethSwitchPkg::mac_t [1:0]  srcMac,
  output ethSwitchPkg::mac_t [1:0]       hostMac,   // Broadcast when nothing learned
  output ethSwitchPkg::boardMap_t [1:0]  boardMap   // Boards seen behind each port
);

  // Ethernet port p is also out-port p, so portActive indexes directly
  always_ff @(posedge RxClk or negedge arstN) begin
    if (!arstN) begin
      hostMac  <= {2{`ETH_BROADCAST_MAC}};
      boardMap <= '0;
    end else begin
      for (int p = `ETH_IDX_ETH1; p <= `ETH_IDX_ETH2; p++) begin
        if (!portActive[p]) begin
          // Link down, forget everything learned on it
          hostMac[p]  <= `ETH_BROADCAST_MAC;
          boardMap[p] <= '0;
        end else if (hdrDone[p]) begin
          // PS or RT interface does not matter, only the board id
          if (srcMac[p][47:24] == `ETH_LCSR_CID) begin
            boardMap[p][srcMac[p][3:0]] <= 1'b1;
          end else begin
            hostMac[p] <= srcMac[p];  // Last non-FPGA sender is the host
          end
        end
      end
    end
  end

  // An inactive port holds nothing one cycle later
  for (genvar p = `ETH_IDX_ETH1; p <= `ETH_IDX_ETH2; p++) begin : gChk
    assert property (@(posedge RxClk) disable iff (!arstN)
      !portActive[p] |=> (boardMap[p] == '0) && (hostMac[p] == `ETH_BROADCAST_MAC));
  end

endmodule

`default_nettype wire

/* rtl/fwdDecision.sv */
// ######################################################################
// Forwarding mask of one Ethernet in-port over Eth1, Eth2, PS and RT
// Registered on hdrDone, so fwdValid follows it by one cycle
// ######################################################################
`include "ethSwitch_settings.svh"
`default_nettype none

module fwdDecision #(
  parameter int inPort = 0  // 0 for Eth1, 1 for Eth2
) (
  input  wire                            RxClk,
  input  wire                            arstN,
  input  wire ethSwitchPkg::ethHeader_t  header,
  input  wire                            hdrDone,
  input  wire ethSwitchPkg::portMask_t   portActive,
  input  wire ethSwitchPkg::boardId_t    boardId,
  input  wire ethSwitchPkg::mac_t [1:0]  hostMac,
  input  wire ethSwitchPkg::boardMap_t [1:0] boardMap,
  output logic                           fwdValid,
  output ethSwitchPkg::portMask_t        fwdMask
);

  ethSwitchPkg::mac_t [`ETH_NUM_PORTS-1:0] primaryMac;  // Indexed by out-port
  ethSwitchPkg::mac_t      destMac;
  ethSwitchPkg::boardId_t  destBoard;
  logic                    isBroadcast;
  logic                    isMulticast;
  logic                    isFpgaDest;
  logic                    noBoardPort;   // Board not seen anywhere and not ourselves
  wire ethSwitchPkg::portMask_t primaryMatch;
  wire ethSwitchPkg::portMask_t maskNext;

  assign destMac   = header.destMac;
  assign destBoard = destMac[3:0];

  assign primaryMac[`ETH_IDX_ETH1] = hostMac[`ETH_IDX_ETH1];
  assign primaryMac[`ETH_IDX_ETH2] = hostMac[`ETH_IDX_ETH2];
  assign primaryMac[`ETH_IDX_PS]   = {`ETH_LCSR_CID, `ETH_FPGA_PS_MAC, 4'd0, boardId};
  assign primaryMac[`ETH_IDX_RT]   = {`ETH_LCSR_CID, `ETH_FPGA_RT_MAC, 4'd0, boardId};

  assign isBroadcast = (destMac == `ETH_BROADCAST_MAC);
  assign isMulticast = (destMac[47:24] == `ETH_LCSR_CID_MCAST) && (destMac[7:0] == 8'hFF);
  assign isFpgaDest  = (destMac[47:24] == `ETH_LCSR_CID);
  assign noBoardPort = !(boardMap[`ETH_IDX_ETH1][destBoard] || boardMap[`ETH_IDX_ETH2][destBoard])
                       && (destBoard != boardId);

  for (genvar o = 0; o < `ETH_NUM_PORTS; o++) begin : gOut
    if (o == inPort) begin : gSelf
      assign primaryMatch[o] = 1'b0;  // Never send back out the in-port
      assign maskNext[o]     = 1'b0;
    end else if ((o == `ETH_IDX_ETH1) || (o == `ETH_IDX_ETH2)) begin : gEth
      logic fpgaMatch;
      logic noMatch;
      assign primaryMatch[o] = (destMac == primaryMac[o]);
      assign fpgaMatch = isFpgaDest && (boardMap[o][destBoard] || noBoardPort);
      assign noMatch   = !(|primaryMatch) && !fpgaMatch;  // Unknown, flood to the other Eth
      assign maskNext[o] = portActive[o] &&
                           (isBroadcast || isMulticast || primaryMatch[o] || fpgaMatch || noMatch);
    end else begin : gFpga
      // PS and RT only take what is addressed to this board
      assign primaryMatch[o] = (destMac == primaryMac[o]);
      assign maskNext[o] = portActive[o] && (isBroadcast || isMulticast || primaryMatch[o]);
    end
  end

  always_ff @(posedge RxClk or negedge arstN) begin
    if (!arstN) begin
      fwdValid <= 1'b0;
      fwdMask  <= '0;
    end else begin
      fwdValid <= hdrDone;
      if (hdrDone) begin
        fwdMask <= maskNext;  // Database as it was before this frame's learning
      end
    end
  end

  assert property (@(posedge RxClk) disable iff (!arstN) fwdValid |-> !fwdMask[inPort]);

endmodule

`default_nettype wire

/* rtl/rxFrameCheck.sv */
// ######################################################################
// Per-port IPv4 header checksum check and receive statistics
// Reports frameDone and ipv4Err one cycle after the parser's frameEnd
// ######################################################################
`include "ethSwitch_settings.svh"
`default_nettype none

module rxFrameCheck (
  input  wire                        RxClk,
  input  wire                        arstN,
  input  wire                        clearErrors,
  input  wire [15:0]                 etherType,
  input  wire                        hdrDone,
  input  wire                        dataStrobe,
  input  wire ethSwitchPkg::byte_t   dataByte,
  input  wire                        frameEnd,
  output logic                       frameDone,
  output logic                       ipv4Err,
  output ethSwitchPkg::rxStats_t     stats
);

  logic        isIpv4;     // Latched from the header
  logic [4:0]  ipByteCnt;  // Saturates at the IPv4 header length
  logic [16:0] cksum;      // Bit 16 holds the carry not yet folded back
  logic        ipHdrSeen;
  logic        cksumOk;
  logic        frameErr;

  assign ipHdrSeen = (ipByteCnt == 5'(`ETH_IPV4_HDR_BYTES));
  assign cksumOk   = (cksum == 17'h0FFFF) || (cksum == 17'h1FFFE);  // 1FFFE folds to FFFF
  assign frameErr  = isIpv4 && !(ipHdrSeen && cksumOk);              // Short IPv4 frame too

  always_ff @(posedge RxClk or negedge arstN) begin
    if (!arstN) begin
      isIpv4    <= 1'b0;
      ipByteCnt <= '0;
      cksum     <= '0;
      frameDone <= 1'b0;
      ipv4Err   <= 1'b0;
      stats     <= '0;
    end else begin
      frameDone <= frameEnd;
      ipv4Err   <= frameEnd && frameErr;
      if (hdrDone) begin
        isIpv4    <= (etherType == `ETH_TYPE_IPV4);
        ipByteCnt <= '0;
        cksum     <= '0;
      end else if (dataStrobe && !ipHdrSeen) begin
        ipByteCnt <= ipByteCnt + 5'd1;
        if (!ipByteCnt[0]) begin
          // High byte of a word, end-around carry added here
          cksum <= {1'b0, cksum[15:0]} + {1'b0, dataByte, 7'd0, cksum[16]};
        end else begin
          cksum <= cksum + {9'd0, dataByte};
        end
      end
      if (frameEnd) begin
        stats.numPacketRecv <= stats.numPacketRecv + 16'd1;
      end
      if (clearErrors) begin
        stats.numIpv4Err <= '0;
      end else if (frameEnd && frameErr) begin
        stats.numIpv4Err <= stats.numIpv4Err + 8'd1;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/rxFrameParser.sv */
// ######################################################################
// Per-port receive FSM, finds the SFD and captures the Ethernet header
// Then strobes each payload byte and pulses frameEnd when valid drops
// ######################################################################
`include "ethSwitch_settings.svh"
`default_nettype none

module rxFrameParser (
  input  wire                      RxClk,
  input  wire                      arstN,
  input  wire ethSwitchPkg::rxBeat_t rxBeat,
  output ethSwitchPkg::ethHeader_t header,
  output logic                     hdrDone,     // Header complete and stable
  output logic                     dataStrobe,
  output ethSwitchPkg::byte_t      dataByte,
  output logic                     frameEnd
);

  ethSwitchPkg::rxState_e rxState;
  logic [3:0]             byteCnt;                    // Header byte index
  ethSwitchPkg::byte_t    hdrBytes [`ETH_HDR_BYTES];  // Raw header bytes in arrival order
  logic                   hdrLast;

  assign hdrLast = (byteCnt == 4'(`ETH_HDR_BYTES - 1));

  // Control path
  always_ff @(posedge RxClk or negedge arstN) begin
    if (!arstN) begin
      rxState    <= ethSwitchPkg::rxIdle;
      byteCnt    <= '0;
      hdrDone    <= 1'b0;
      dataStrobe <= 1'b0;
      frameEnd   <= 1'b0;
    end else begin
      hdrDone    <= 1'b0;  // All status outputs are single pulses
      dataStrobe <= 1'b0;
      frameEnd   <= 1'b0;
      case (rxState)
        ethSwitchPkg::rxIdle: begin
          byteCnt <= '0;
          // No check on preamble contents, just wait for the delimiter
          if (rxBeat.valid && (rxBeat.data == `ETH_SFD)) begin
            rxState <= ethSwitchPkg::rxHeader;
          end
        end
        ethSwitchPkg::rxHeader: begin
          if (!rxBeat.valid) begin
            rxState <= ethSwitchPkg::rxIdle;  // Runt frame, dropped silently
          end else if (hdrLast) begin
            hdrDone <= 1'b1;
            rxState <= ethSwitchPkg::rxData;
          end else begin
            byteCnt <= byteCnt + 4'd1;
          end
        end
        ethSwitchPkg::rxData: begin
          if (rxBeat.valid) begin
            dataStrobe <= 1'b1;
          end else begin
            frameEnd <= 1'b1;                 // First idle cycle ends the frame
            rxState  <= ethSwitchPkg::rxIdle;
          end
        end
        default: rxState <= ethSwitchPkg::rxIdle;
      endcase
    end
  end

  // Data path
  always_ff @(posedge RxClk) begin
    dataByte <= rxBeat.data;  // Lines up with dataStrobe
    if ((rxState == ethSwitchPkg::rxHeader) && rxBeat.valid) begin
      hdrBytes[byteCnt] <= rxBeat.data;
    end
  end

  // Network byte order, first byte on the wire is the MSB
  always_comb begin
    for (int i = 0; i < `ETH_MAC_BYTES; i++) begin
      header.destMac[47 - 8*i -: 8] = hdrBytes[`ETH_DEST_MAC_OFS + i];
      header.srcMac[47 - 8*i -: 8]  = hdrBytes[`ETH_SRC_MAC_OFS + i];
    end
    header.etherType = {hdrBytes[`ETH_TYPE_OFS], hdrBytes[`ETH_TYPE_OFS + 1]};
  end

  // Header end and frame end come from different states and never overlap
  assert property (@(posedge RxClk) disable iff (!arstN) !(hdrDone && frameEnd));

endmodule

`default_nettype wire

/* test/ethRxSwitchTb.sv */
// ######################################################################
// Table-driven testbench of the receive switch, one frame per entry
// Checks forwarding masks, IPv4 errors and counters against the table
// ######################################################################
`include "ethSwitch_settings.svh"
`default_nettype none

module ethRxSwitchTb;
  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    logic                    inPort;     // 0 is Eth1, 1 is Eth2
    ethSwitchPkg::portMask_t active;
    ethSwitchPkg::mac_t      dst;
    ethSwitchPkg::mac_t      src;
    logic [15:0]             etherType;
    logic [7:0]              payLen;
    logic [2:0]              flags;      // Bad checksum, abandon in header, clearErrors
    ethSwitchPkg::portMask_t expMask;
    logic                    expErr;
    ethSwitchPkg::count16_t  expRecv;
    ethSwitchPkg::count16_t  expIpErr;
  } frameEntry_t;

  localparam ethSwitchPkg::boardId_t ourBoard = 4'd3;
  localparam ethSwitchPkg::mac_t bcastMac   = `ETH_BROADCAST_MAC;
  localparam ethSwitchPkg::mac_t mcastMac   = {`ETH_LCSR_CID_MCAST, 24'h0000FF};
  localparam ethSwitchPkg::mac_t psMac      = {`ETH_LCSR_CID, `ETH_FPGA_PS_MAC, 4'd0, ourBoard};
  localparam ethSwitchPkg::mac_t rtMac      = {`ETH_LCSR_CID, `ETH_FPGA_RT_MAC, 4'd0, ourBoard};
  localparam ethSwitchPkg::mac_t hostA      = 48'h0200_0011_2233;  // Host behind Eth1
  localparam ethSwitchPkg::mac_t hostH      = 48'h0200_00AA_BB01;  // Host behind Eth2
  localparam ethSwitchPkg::mac_t unknownMac = 48'h0200_0099_9999;
  localparam ethSwitchPkg::mac_t board5Src  = {`ETH_LCSR_CID, `ETH_FPGA_PS_MAC, 8'h05};
  localparam ethSwitchPkg::mac_t board5Dst  = {`ETH_LCSR_CID, 16'hAB00, 8'h05};  // Not primary
  localparam logic [15:0] typeIp    = `ETH_TYPE_IPV4;
  localparam logic [15:0] typeOther = 16'h88B5;

  logic                              RxClk;
  logic                              arstN;
  ethSwitchPkg::rxBeat_t [1:0]       rxIn;
  ethSwitchPkg::portMask_t           portActive;
  ethSwitchPkg::boardId_t            boardId;
  logic                              clearErrors;
  ethSwitchPkg::rxResult_t [1:0]     dutResult;
  ethSwitchPkg::rxStats_t [1:0]      dutStats;

  frameEntry_t         entryQ [$];
  string               nameQ [$];
  ethSwitchPkg::byte_t payload [64];
  logic [31:0]         rngState = 32'd17768;
  logic                curPort;              // In-port under test, watched by the monitor
  int                  fwdCount = 0;
  int                  doneCount = 0;
  ethSwitchPkg::portMask_t lastMask;
  logic                    lastErr;
  ethSwitchPkg::count16_t  lastRecv;
  ethSwitchPkg::count16_t  lastIpErr;
  int                  cycleCnt = 0;
  int                  cycleLimit = 0;       // Zero until the table is built

  tbClkGen clkGen_i (.RxClk(RxClk), .arstN(arstN));

  ethRxSwitch dut_i (
    .RxClk       (RxClk),
    .arstN       (arstN),
    .rxIn        (rxIn),
    .portActive  (portActive),
    .boardId     (boardId),
    .clearErrors (clearErrors),
    .rxResult    (dutResult),
    .rxStats     (dutStats)
  );

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic checkMask(input string name, input ethSwitchPkg::portMask_t expVal,
                           input ethSwitchPkg::portMask_t actVal);
    if (actVal !== expVal) begin
      abortRun($sformatf("CHECK FAILED %s: expected %h, actual %h", name, expVal, actVal));
    end
  endtask

  task automatic checkFlag(input string name, input logic expVal, input logic actVal);
    if (actVal !== expVal) begin
      abortRun($sformatf("CHECK FAILED %s: expected %b, actual %b", name, expVal, actVal));
    end
  endtask

  task automatic checkCount(input string name, input ethSwitchPkg::count16_t expVal,
                            input ethSwitchPkg::count16_t actVal);
    if (actVal !== expVal) begin
      abortRun($sformatf("CHECK FAILED %s: expected %0d, actual %0d", name, expVal, actVal));
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic addEntry(input string name, input logic port, input ethSwitchPkg::portMask_t act,
                          input ethSwitchPkg::mac_t dst, input ethSwitchPkg::mac_t src,
                          input logic [15:0] eType, input logic [7:0] len, input logic [2:0] flags,
                          input ethSwitchPkg::portMask_t expMask, input logic expErr,
                          input ethSwitchPkg::count16_t expRecv,
                          input ethSwitchPkg::count16_t expIpErr);
    frameEntry_t e;
    e = '{port, act, dst, src, eType, len, flags, expMask, expErr, expRecv, expIpErr};
    entryQ.push_back(e);
    nameQ.push_back(name);
  endtask

  // Flags are {bad checksum, abandon, clearErrors}, masks are {RT, PS, Eth2, Eth1}
  task automatic buildTable();
    addEntry("bcast all up", 1'b0, 4'hF, bcastMac, hostA, typeOther, 8'd30, 3'b000,
             4'hE, 1'b0, 16'd1, 16'd0);
    addEntry("mcast all up", 1'b0, 4'hF, mcastMac, hostA, typeOther, 8'd30, 3'b000,
             4'hE, 1'b0, 16'd2, 16'd0);
    addEntry("bcast rt down", 1'b0, 4'h7, bcastMac, hostA, typeOther, 8'd30, 3'b000,
             4'h6, 1'b0, 16'd3, 16'd0);
    addEntry("to ps mac", 1'b0, 4'hF, psMac, hostA, typeOther, 8'd30, 3'b000,
             4'h4, 1'b0, 16'd4, 16'd0);
    addEntry("to rt mac", 1'b0, 4'hF, rtMac, hostA, typeOther, 8'd30, 3'b000,
             4'h8, 1'b0, 16'd5, 16'd0);
    addEntry("unknown host", 1'b0, 4'hF, unknownMac, hostA, typeOther, 8'd30, 3'b000,
             4'h2, 1'b0, 16'd6, 16'd0);
    addEntry("learn host H", 1'b1, 4'hF, bcastMac, hostH, typeOther, 8'd30, 3'b000,
             4'hD, 1'b0, 16'd1, 16'd0);
    addEntry("to learned H", 1'b0, 4'hF, hostH, hostA, typeOther, 8'd30, 3'b000,
             4'h2, 1'b0, 16'd7, 16'd0);
    addEntry("learn board 5", 1'b1, 4'hF, bcastMac, board5Src, typeOther, 8'd30, 3'b000,
             4'hD, 1'b0, 16'd2, 16'd0);
    addEntry("to board 5", 1'b0, 4'hF, board5Dst, hostA, typeOther, 8'd30, 3'b000,
             4'h2, 1'b0, 16'd8, 16'd0);
    addEntry("eth2 down", 1'b0, 4'hD, bcastMac, hostA, typeOther, 8'd30, 3'b000,
             4'hC, 1'b0, 16'd9, 16'd0);
    // H is forgotten now, so the frame floods to Eth2 through noMatch
    addEntry("H after flush", 1'b0, 4'hF, hostH, hostA, typeOther, 8'd30, 3'b000,
             4'h2, 1'b0, 16'd10, 16'd0);
    addEntry("ipv4 good", 1'b0, 4'hF, unknownMac, hostA, typeIp, 8'd40, 3'b000,
             4'h2, 1'b0, 16'd11, 16'd0);
    addEntry("ipv4 bad", 1'b0, 4'hF, unknownMac, hostA, typeIp, 8'd40, 3'b100,
             4'h2, 1'b1, 16'd12, 16'd1);
    addEntry("not ipv4", 1'b0, 4'hF, unknownMac, hostA, typeOther, 8'd24, 3'b000,
             4'h2, 1'b0, 16'd13, 16'd1);
    addEntry("ipv4 short", 1'b0, 4'hF, unknownMac, hostA, typeIp, 8'd12, 3'b000,
             4'h2, 1'b1, 16'd14, 16'd2);
    addEntry("eth2 ipv4 bad", 1'b1, 4'hF, hostA, hostH, typeIp, 8'd40, 3'b100,
             4'h1, 1'b1, 16'd3, 16'd1);
    addEntry("clear errors", 1'b0, 4'hF, unknownMac, hostA, typeIp, 8'd40, 3'b001,
             4'h2, 1'b0, 16'd15, 16'd0);
    addEntry("bad after clear", 1'b0, 4'hF, unknownMac, hostA, typeIp, 8'd40, 3'b100,
             4'h2, 1'b1, 16'd16, 16'd1);
    addEntry("abandoned", 1'b0, 4'hF, unknownMac, hostA, typeOther, 8'd30, 3'b010,
             4'h0, 1'b0, 16'd16, 16'd1);
  endtask

  // Random payload, IPv4 frames get a 20-byte header with its checksum
  task automatic buildPayload(input frameEntry_t e);
    logic [16:0] acc;
    logic [15:0] word;
    for (int i = 0; i < 64; i++) begin
      rngState   = xorshift32(rngState);
      payload[i] = rngState[7:0];
    end
    if (e.etherType == `ETH_TYPE_IPV4) begin
      payload[0]  = 8'h45;  // Version 4, five header words
      payload[10] = 8'h00;  // Checksum field zero while summing
      payload[11] = 8'h00;
      acc = '0;
      for (int w = 0; w < `ETH_IPV4_HDR_BYTES / 2; w++) begin
        word = {payload[2*w], payload[2*w + 1]};
        acc  = {1'b0, acc[15:0]} + {1'b0, word};
        acc  = {1'b0, acc[15:0]} + {16'd0, acc[16]};  // End-around carry
      end
      payload[10] = ~acc[15:8];
      payload[11] = ~acc[7:0];
      if (e.flags[2]) begin
        payload[0] = payload[0] ^ 8'h10;  // Corrupt after the checksum is set
      end
    end
  endtask

  task automatic driveByte(input logic port, input ethSwitchPkg::byte_t b);
    rxIn[port].valid = 1'b1;
    rxIn[port].data  = b;
    @(posedge RxClk);
    #1;
  endtask

  task automatic idleFor(input int cycles);
    rxIn = '0;
    repeat (cycles) begin
      @(posedge RxClk);
      #1;
    end
  endtask

  task automatic sendFrame(input frameEntry_t e);
    ethSwitchPkg::ethHeader_t hdr;
    int hdrLen;
    hdr    = '{e.dst, e.src, e.etherType};
    hdrLen = e.flags[1] ? 6 : `ETH_HDR_BYTES;  // Abandoned frames stop inside the header
    buildPayload(e);
    for (int i = 0; i < 7; i++) begin
      driveByte(e.inPort, 8'h55);             // Preamble
    end
    driveByte(e.inPort, `ETH_SFD);
    for (int i = 0; i < hdrLen; i++) begin
      driveByte(e.inPort, hdr[`ETH_HDR_BYTES*8 - 1 - 8*i -: 8]);
    end
    if (!e.flags[1]) begin
      for (int i = 0; i < int'(e.payLen); i++) begin
        driveByte(e.inPort, payload[i]);
      end
    end
    rxIn[e.inPort] = '0;
  endtask

  task automatic runEntry(input int idx);
    frameEntry_t e;
    string       name;
    int          fwdStart;
    int          doneStart;
    int          waitCnt;
    e           = entryQ[idx];
    name        = nameQ[idx];
    fwdStart    = fwdCount;
    doneStart   = doneCount;
    curPort     = e.inPort;
    portActive  = e.active;
    clearErrors = e.flags[0];
    @(posedge RxClk);
    #1;
    clearErrors = 1'b0;
    sendFrame(e);
    if (e.flags[1]) begin
      idleFor(12);
      if (fwdCount != fwdStart) abortRun({name, ": fwdValid pulsed for an abandoned frame"});
      if (doneCount != doneStart) abortRun({name, ": frameDone pulsed for an abandoned frame"});
      checkCount({name, " numPacketRecv"}, e.expRecv, dutStats[e.inPort].numPacketRecv);
    end else begin
      waitCnt = 0;
      while ((doneCount == doneStart) && (waitCnt < 100)) begin
        @(posedge RxClk);
        #1;
        waitCnt++;
      end
      if (doneCount == doneStart) abortRun({name, ": frameDone did not pulse within 100 cycles"});
      if (fwdCount == fwdStart) abortRun({name, ": fwdValid never pulsed for this frame"});
      checkMask({name, " fwdMask"}, e.expMask, lastMask);
      checkFlag({name, " ipv4Err"}, e.expErr, lastErr);
      checkCount({name, " numPacketRecv"}, e.expRecv, lastRecv);
      checkCount({name, " numIpv4Err"}, e.expIpErr, lastIpErr);
      idleFor(12);                            // Interframe gap
    end
  endtask

  // Pulses sampled mid-cycle, away from the driving edge
  always @(negedge RxClk) begin
    if (dutResult[curPort].fwdValid) begin
      fwdCount <= fwdCount + 1;
      lastMask <= dutResult[curPort].fwdMask;
    end
    if (dutResult[curPort].frameDone) begin
      doneCount <= doneCount + 1;
      lastErr   <= dutResult[curPort].ipv4Err;
      lastRecv  <= dutStats[curPort].numPacketRecv;
      lastIpErr <= {8'd0, dutStats[curPort].numIpv4Err};
    end
  end

  // Watchdog
  always @(posedge RxClk) begin
    cycleCnt <= cycleCnt + 1;
    if ((cycleLimit > 0) && (cycleCnt > cycleLimit)) begin
      abortRun("Timeout, the run went past its cycle limit");
    end
  end

  initial begin
    rxIn        = '0;
    portActive  = 4'hF;
    boardId     = ourBoard;
    clearErrors = 1'b0;
    curPort     = 1'b0;
    buildTable();
    cycleLimit = entryQ.size() * 120 + 50;  // Worst-case entry length plus reset
    @(posedge arstN);
    @(posedge RxClk);
    #1;
    for (int i = 0; i < entryQ.size(); i++) begin
      runEntry(i);
    end
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

/* test/tbClkGen.sv */
// ######################################################################
// Testbench clock and reset, RxClk at 8 ns and arstN low for 8 cycles
// ######################################################################
`default_nettype none

module tbClkGen (
  output logic RxClk,
  output logic arstN
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    RxClk = 1'b0;
    forever #4 RxClk = ~RxClk;  // 8 ns period
  end

  initial begin
    arstN = 1'b0;
    repeat (8) @(posedge RxClk);
    #1 arstN = 1'b1;            // Released just after an edge
  end

endmodule

`default_nettype wire
